// File: include/finv_settings.svh
// field widths, estimate width, seed index width and Newton stage count
`ifndef FINV_SETTINGS_SVH
`define FINV_SETTINGS_SVH

// single-precision fields
`define FINV_EXP_W 8
`define FINV_MAN_W 23
`define FINV_WORD_W 32

// fixed-point estimate and product arithmetic
`define FINV_EST_W 64

// top mantissa bits that address the seed table
`define FINV_SEED_IDX_W 5

// refinement depth, each stage roughly doubles the correct bits
`define FINV_NEWTON_STAGES 3

`endif

// File: include/finv_seed_table.svh
// seed table case items, 256 * (2/(1+f) - 1) at each interval midpoint
`ifndef FINV_SEED_TABLE_SVH
`define FINV_SEED_TABLE_SVH

            5'd0:  seed = 8'd248;
            5'd1:  seed = 8'd233;
            5'd2:  seed = 8'd219;
            5'd3:  seed = 8'd206;
            5'd4:  seed = 8'd193;
            5'd5:  seed = 8'd181;
            5'd6:  seed = 8'd170;
            5'd7:  seed = 8'd159;
            5'd8:  seed = 8'd149;
            5'd9:  seed = 8'd139;
            5'd10: seed = 8'd130;
            5'd11: seed = 8'd121;
            5'd12: seed = 8'd112;
            5'd13: seed = 8'd104;
            5'd14: seed = 8'd96;
            5'd15: seed = 8'd89;
            5'd16: seed = 8'd82;
            5'd17: seed = 8'd75;
            5'd18: seed = 8'd68;
            5'd19: seed = 8'd62;
            5'd20: seed = 8'd56;
            5'd21: seed = 8'd50;
            5'd22: seed = 8'd45;
            5'd23: seed = 8'd39;
            5'd24: seed = 8'd34;
            5'd25: seed = 8'd29;
            5'd26: seed = 8'd24;
            5'd27: seed = 8'd19;
            5'd28: seed = 8'd15;
            5'd29: seed = 8'd10;
            5'd30: seed = 8'd6;
            5'd31: seed = 8'd2;

`endif

// File: rtl/finv_pkg.sv
// vector types and the pipeline item struct of the reciprocal unit
`include "finv_settings.svh"

package finv_pkg;

    // raw ieee single word
    typedef logic [`FINV_WORD_W-1:0] float_word_t;

    // biased exponent
    typedef logic [`FINV_EXP_W-1:0] exponent_t;

    // stored fraction, hidden one not included
    typedef logic [`FINV_MAN_W-1:0] mantissa_t;

    // fixed point estimate of 2/(1.f), integer one at bit 31
    typedef logic [`FINV_EST_W-1:0] estimate_t;

    // one operand in flight between stages
    typedef struct packed {
        logic      valid;
        logic      sign;
        exponent_t exponent;
        mantissa_t mantissa;
        estimate_t estimate;
    } finv_item_t;

endpackage

// File: rtl/finv_seed.sv
// operand split and seed table lookup, first pipeline stage
`timescale 1ns/10ps
`include "finv_settings.svh"

module finv_seed (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  finv_pkg::float_word_t operand,
    output finv_pkg::finv_item_t  item
);

    localparam int SEED_W = 8;
    // seed byte lands directly below the integer one
    localparam int SEED_LSB = `FINV_EST_W / 2 - 1 - SEED_W;

    logic                        sign;
    finv_pkg::exponent_t         exponent;
    finv_pkg::mantissa_t         mantissa;
    logic [`FINV_SEED_IDX_W-1:0] seed_idx;
    logic [SEED_W-1:0]           seed;
    finv_pkg::estimate_t         estimate;

    assign sign     = operand[`FINV_WORD_W-1];
    assign exponent = operand[`FINV_WORD_W-2 -: `FINV_EXP_W];
    assign mantissa = operand[`FINV_MAN_W-1:0];

    // table addressed by the leading fraction bits
    assign seed_idx = mantissa[`FINV_MAN_W-1 -: `FINV_SEED_IDX_W];

    always_comb begin
        case (seed_idx)
`include "finv_seed_table.svh"
            default: seed = '0;
        endcase
    end

    // 1.seed, lower bits left at zero
    assign estimate = finv_pkg::estimate_t'({1'b1, seed}) << SEED_LSB;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            item <= '0;
        end else begin
            item.valid    <= in_valid;
            item.sign     <= sign;
            item.exponent <= exponent;
            item.mantissa <= mantissa;
            item.estimate <= estimate;
        end
    end

endmodule

// File: rtl/finv_newton_stage.sv
// one registered Newton-Raphson refinement of the reciprocal estimate
`timescale 1ns/10ps
`include "finv_settings.svh"

module finv_newton_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  finv_pkg::finv_item_t item_in,
    output finv_pkg::finv_item_t item_out
);

    // 1.f with its hidden one aligned to the estimate's integer bit
    localparam int TARGET_SHIFT = `FINV_EST_W / 2 - 1 - `FINV_MAN_W;
    localparam int SHIFT_FIRST  = `FINV_EST_W / 2 - 1;
    localparam int SHIFT_SECOND = `FINV_EST_W / 2;

    finv_pkg::estimate_t target;
    finv_pkg::estimate_t est;
    finv_pkg::estimate_t est_twice;
    finv_pkg::estimate_t prod_tx;
    finv_pkg::estimate_t prod_tx_scaled;
    finv_pkg::estimate_t prod_txx;
    finv_pkg::estimate_t correction;
    finv_pkg::estimate_t est_next;

    assign target = finv_pkg::estimate_t'({1'b1, item_in.mantissa}) << TARGET_SHIFT;
    assign est    = item_in.estimate;

    // x' = 2x - t*x*x, scaled so both terms share the binary point
    assign est_twice      = est << 1;
    assign prod_tx        = target * est;
    assign prod_tx_scaled = prod_tx >> SHIFT_FIRST;
    assign prod_txx       = prod_tx_scaled * est;
    assign correction     = prod_txx >> SHIFT_SECOND;
    assign est_next       = est_twice - correction;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            item_out <= '0;
        end else begin
            item_out.valid    <= item_in.valid;
            item_out.sign     <= item_in.sign;
            item_out.exponent <= item_in.exponent;
            item_out.mantissa <= item_in.mantissa;
            item_out.estimate <= est_next;
        end
    end

endmodule

// File: rtl/finv_pack.sv
// result exponent, round-to-nearest-even mantissa and output word register
`timescale 1ns/10ps
`include "finv_settings.svh"

module finv_pack (
    input  logic                  clk,
    input  logic                  arst_n,
    input  finv_pkg::finv_item_t  item,
    output logic                  out_valid,
    output finv_pkg::float_word_t result
);

    localparam finv_pkg::exponent_t EXP_HI = finv_pkg::exponent_t'(254);
    localparam finv_pkg::exponent_t EXP_LO = finv_pkg::exponent_t'(253);

    // integer one of the estimate and the ulp of the kept fraction
    localparam int ONE_BIT = `FINV_EST_W / 2 - 1;
    localparam int ULP_BIT = ONE_BIT - `FINV_MAN_W;

    finv_pkg::estimate_t est;
    logic                man_zero;
    logic                exp_hi;
    logic                exp_lo;
    logic                ulp;
    logic                guard;
    logic                rnd;
    logic                sticky;
    logic                round_up;
    finv_pkg::exponent_t exp_res;
    finv_pkg::mantissa_t man_res;

    assign est      = item.estimate;
    assign man_zero = (item.mantissa == '0);
    assign exp_hi   = (item.exponent == EXP_HI);
    assign exp_lo   = (item.exponent == EXP_LO);

    assign ulp    = est[ULP_BIT];
    assign guard  = est[ULP_BIT-1];
    assign rnd    = est[ULP_BIT-2];
    assign sticky = |est[ULP_BIT-3:0];

    // above half, or exactly half with an odd ulp
    assign round_up = guard & (rnd | sticky | ulp);

    always_comb begin
        if (exp_hi) begin
            exp_res = '0;
        end else if (man_zero) begin
            exp_res = EXP_HI - item.exponent;
        end else begin
            exp_res = EXP_LO - item.exponent;
        end
    end

    // near the top of the range the result goes subnormal, no rounding there
    always_comb begin
        if (exp_lo) begin
            man_res = est[ONE_BIT:ULP_BIT+1];
        end else if (exp_hi) begin
            man_res = est[ONE_BIT+1:ULP_BIT+2];
        end else if (man_zero) begin
            man_res = '0;
        end else begin
            man_res = est[ONE_BIT-1:ULP_BIT] + finv_pkg::mantissa_t'(round_up);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= item.valid;
            result    <= {item.sign, exp_res, man_res};
        end
    end

endmodule

// File: rtl/finv_top.sv
// reciprocal unit top, seed stage, Newton chain and packer
`timescale 1ns/10ps
`include "finv_settings.svh"

module finv_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  finv_pkg::float_word_t operand,
    output logic                  out_valid,
    output finv_pkg::float_word_t result
);

    // stage boundaries, index 0 is the seed output
    finv_pkg::finv_item_t stage_item [0:`FINV_NEWTON_STAGES];

    finv_seed u_seed (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .operand  (operand),
        .item     (stage_item[0])
    );

    for (genvar i = 0; i < `FINV_NEWTON_STAGES; i++) begin : g_newton
        finv_newton_stage u_newton (
            .clk      (clk),
            .arst_n   (arst_n),
            .item_in  (stage_item[i]),
            .item_out (stage_item[i+1])
        );
    end

    finv_pack u_pack (
        .clk       (clk),
        .arst_n    (arst_n),
        .item      (stage_item[`FINV_NEWTON_STAGES]),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

// File: verification/finv_checker.sv
// output checker with expected-result queue, tolerance compare and counters
`timescale 1ns/10ps

module finv_checker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  finv_pkg::float_word_t operand,
    input  logic                  out_valid,
    input  finv_pkg::float_word_t result,
    input  logic                  exp_valid,
    input  finv_pkg::float_word_t exp_word,
    input  logic                  exp_exact,
    input  logic                  end_of_test,
    output int                    out_count,
    output int                    pass_count,
    output int                    fail_count
);

    typedef struct packed {
        finv_pkg::float_word_t operand;
        finv_pkg::float_word_t expected;
        logic                  exact;
    } expect_entry_t;

    expect_entry_t pending[$];
    expect_entry_t entry;
    expect_entry_t head;
    int            in_count;
    int            errors;
    int            passes;
    logic          end_seen;

    // rebias a normal single into a double
    function automatic real word_to_real(input finv_pkg::float_word_t w);
        logic [63:0] bits;
        bits = {w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'd0};
        return $bitstoreal(bits);
    endfunction

    function automatic logic result_ok(input finv_pkg::float_word_t got,
                                       input expect_entry_t e);
        real got_val;
        real want_val;
        real ulp_val;
        real diff;
        if (e.exact) begin
            return got == e.expected;
        end
        // exponent 254 operands, only sign and exponent are defined
        if (e.expected[30:23] == 8'd0) begin
            return got[31:23] == e.expected[31:23];
        end
        got_val  = word_to_real(got);
        want_val = word_to_real(e.expected);
        ulp_val  = word_to_real({1'b0, e.expected[30:23], 23'd1})
                 - word_to_real({1'b0, e.expected[30:23], 23'd0});
        diff     = got_val - want_val;
        if (diff < 0.0) begin
            diff = -diff;
        end
        return diff <= 2.0 * ulp_val;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending.delete();
            end_seen = 1'b0;
            in_count   <= 0;
            out_count  <= 0;
            pass_count <= 0;
            fail_count <= 0;
        end else begin
            errors = 0;
            passes = 0;
            if (exp_valid) begin
                entry.operand  = operand;
                entry.expected = exp_word;
                entry.exact    = exp_exact;
                pending.push_back(entry);
            end
            if (in_valid) begin
                in_count <= in_count + 1;
            end
            if (out_valid) begin
                out_count <= out_count + 1;
                if (pending.size() == 0) begin
                    $display("checker: result %h came out at %0t with no input waiting for it",
                             result, $time);
                    errors++;
                end else begin
                    head = pending.pop_front();
                    if (result_ok(result, head)) begin
                        $display("test %0d: operand %h result %h ok",
                                 out_count + 1, head.operand, result);
                        passes++;
                    end else begin
                        $display("MISMATCH at %0t: test %0d operand %h expected %h got %h",
                                 $time, out_count + 1, head.operand, head.expected, result);
                        errors++;
                    end
                end
            end
            if (end_of_test && !end_seen) begin
                end_seen = 1'b1;
                if (pending.size() != 0) begin
                    $display("checker: %0d expected results were never produced",
                             pending.size());
                    errors++;
                end
                if (in_count != out_count) begin
                    $display("checker: %0d inputs went in but %0d outputs came out",
                             in_count, out_count);
                    errors++;
                end
            end
            pass_count <= pass_count + passes;
            fail_count <= fail_count + errors;
        end
    end

endmodule

// File: verification/finv_tb.sv
// reciprocal unit testbench top with clock, reset, stimulus table and run control
`timescale 1ns/10ps
`include "finv_settings.svh"

module finv_tb;

    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = `FINV_NEWTON_STAGES + 2;
    localparam int MARGIN       = 20;
    localparam int RANDOM_ROWS  = 24;

    typedef struct packed {
        finv_pkg::float_word_t operand;
        finv_pkg::float_word_t expected;
        logic                  exact;
        logic [3:0]            gap;
    } stim_row_t;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  in_valid;
    finv_pkg::float_word_t operand;
    logic                  out_valid;
    finv_pkg::float_word_t result;
    logic                  exp_valid;
    finv_pkg::float_word_t exp_word;
    logic                  exp_exact;
    logic                  end_of_test;
    int                    out_count;
    int                    pass_count;
    int                    fail_count;

    stim_row_t stim_rows[$];
    int        idle_cycles;
    int        cycle_count = 0;
    int        cycle_limit;
    int        seed;

    finv_top UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .operand   (operand),
        .out_valid (out_valid),
        .result    (result)
    );

    finv_checker out_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .operand     (operand),
        .out_valid   (out_valid),
        .result      (result),
        .exp_valid   (exp_valid),
        .exp_word    (exp_word),
        .exp_exact   (exp_exact),
        .end_of_test (end_of_test),
        .out_count   (out_count),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    always #20 clk = ~clk;

    function automatic real word_to_real(input finv_pkg::float_word_t w);
        logic [63:0] bits;
        bits = {w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'd0};
        return $bitstoreal(bits);
    endfunction

    // double back to single, nearest even on the dropped bits
    function automatic finv_pkg::float_word_t real_to_word(input real r);
        logic [63:0] bits;
        logic [10:0] exp_field;
        logic [30:0] magnitude;
        logic        round_up;
        bits      = $realtobits(r);
        exp_field = bits[62:52] - 11'd896;
        magnitude = {exp_field[7:0], bits[51:29]};
        round_up  = bits[28] & (bits[29] | (|bits[27:0]));
        magnitude = magnitude + 31'(round_up);
        return {bits[63], magnitude};
    endfunction

    task automatic add_row(input finv_pkg::float_word_t op, input finv_pkg::float_word_t expected,
                           input logic exact, input int gap);
        stim_row_t row;
        row.operand  = op;
        row.expected = expected;
        row.exact    = exact;
        row.gap      = 4'(gap);
        stim_rows.push_back(row);
        idle_cycles += gap;
    endtask

    task automatic add_random_rows(input int count);
        logic [31:0]           raw_a;
        logic [31:0]           raw_b;
        logic [7:0]            exp_field;
        finv_pkg::float_word_t op;
        for (int i = 0; i < count; i++) begin
            raw_a     = $random(seed);
            raw_b     = $random(seed);
            // exponents 1 to 252 keep the result normal
            exp_field = 8'(32'd1 + raw_b % 32'd252);
            op        = {raw_a[31], exp_field, raw_a[22:0]};
            add_row(op, real_to_word(1.0 / word_to_real(op)), 1'b0, (i % 6 == 5) ? 2 : 0);
        end
    endtask

    task automatic build_table();
        // powers of two, exact
        add_row(32'h3f800000, 32'h3f800000, 1'b1, 0);
        add_row(32'h40000000, 32'h3f000000, 1'b1, 0);
        add_row(32'h3e800000, 32'h40800000, 1'b1, 0);
        add_row(32'hc1000000, 32'hbe000000, 1'b1, 2);
        add_row(32'h00800000, 32'h7e800000, 1'b1, 0);
        add_row(32'h7e000000, 32'h01000000, 1'b1, 1);
        // general mantissas with negative twins
        add_row(32'h40400000, 32'h3eaaaaab, 1'b0, 0);
        add_row(32'hc0400000, 32'hbeaaaaab, 1'b0, 0);
        add_row(32'h41200000, 32'h3dcccccd, 1'b0, 0);
        add_row(32'hc1200000, 32'hbdcccccd, 1'b0, 3);
        add_row(32'h40e00000, 32'h3e124925, 1'b0, 0);
        add_row(32'hc0e00000, 32'hbe124925, 1'b0, 0);
        add_row(32'h3fc00000, 32'h3f2aaaab, 1'b0, 0);
        add_row(32'h3fa00000, 32'h3f4ccccd, 1'b0, 0);
        add_row(32'h3f400000, 32'h3faaaaab, 1'b0, 1);
        add_row(32'h00c00000, 32'h7e2aaaab, 1'b0, 0);
        add_row(32'h7e400000, 32'h00aaaaab, 1'b0, 0);
        // exponent 254, sign and zero exponent only
        add_row(32'h7f000000, 32'h00000000, 1'b0, 0);
        add_row(32'hff400000, 32'h80000000, 1'b0, 2);
        add_random_rows(RANDOM_ROWS);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles with %0d of %0d results seen",
                     cycle_count, out_count, stim_rows.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        operand     = '0;
        exp_valid   = 1'b0;
        exp_word    = '0;
        exp_exact   = 1'b0;
        end_of_test = 1'b0;
        seed        = 32'hc991;
        idle_cycles = 0;
        build_table();
        cycle_limit = RESET_CYCLES + stim_rows.size() + idle_cycles + LATENCY + MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        foreach (stim_rows[i]) begin
            @(posedge clk);
            in_valid  <= 1'b1;
            operand   <= stim_rows[i].operand;
            exp_valid <= 1'b1;
            exp_word  <= stim_rows[i].expected;
            exp_exact <= stim_rows[i].exact;
            for (int g = 0; g < int'(stim_rows[i].gap); g++) begin
                @(posedge clk);
                in_valid  <= 1'b0;
                exp_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid  <= 1'b0;
        exp_valid <= 1'b0;

        while (out_count < stim_rows.size()) begin
            @(posedge clk);
        end
        // room for a stray out_valid to show up
        repeat (LATENCY) @(posedge clk);
        end_of_test <= 1'b1;
        repeat (2) @(posedge clk);

        $display("summary: %0d passed, %0d failed, %0d rows",
                 pass_count, fail_count, stim_rows.size());
        if (fail_count == 0 && pass_count == stim_rows.size()) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
rtl/finv_pkg.sv
rtl/finv_seed.sv
rtl/finv_newton_stage.sv
rtl/finv_pack.sv
rtl/finv_top.sv
verification/finv_checker.sv
verification/finv_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the reciprocal unit testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f all.f --top-module finv_tb -o finv_sim

./obj_dir/finv_sim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished, log in sim.log"
